//--- tb/issue_stimulus.txt
# rst valid instr0 instr1 instr2 instr3 wb stall mask busy next_valid next_thread next_instr next_dest
# All columns are hex except next_dest, a decimal scoreboard bit where 64 means no destination
0 0 0000000 0000000 0000000 0000000 000 0 0 0 0 0 0000000 64
0 f 0208000 0210000 0218000 0220000 000 0 1 0 1 0 0208000 64
0 f 0208000 0210000 0218000 0220000 000 0 2 0 1 1 0210000 64
0 f 0208000 0210000 0218000 0220000 000 0 4 0 1 2 0218000 64
0 f 0208000 0210000 0218000 0220000 000 0 8 0 1 3 0220000 64
0 f 0208000 0210000 0218000 0220000 000 0 1 0 1 0 0208000 64
0 2 0000000 000008a 0000000 0000000 000 0 2 0 1 1 000008a 5
0 2 0000000 0228000 0000000 0000000 000 0 0 2 0 0 0000000 64
0 2 0000000 000008a 0000000 0000000 000 0 0 2 0 0 0000000 64
0 2 0000000 0228000 0000000 0000000 145 0 0 2 0 0 0000000 64
0 2 0000000 0228000 0000000 0000000 000 0 2 0 1 1 0228000 64
0 4 0000000 0000000 00000be 0000000 000 0 4 0 1 2 00000be 31
0 4 0000000 0000000 03100c7 0000000 000 0 0 4 0 0 0000000 64
0 4 0000000 0000000 03100c7 0000000 19f 0 0 4 0 0 0000000 64
0 4 0000000 0000000 03100c7 0000000 000 0 4 0 1 2 03100c7 35
0 8 0000000 0000000 0000000 00000ca 000 0 8 4 1 3 00000ca 37
0 8 0000000 0000000 0000000 0228000 000 0 8 c 1 3 0228000 64
0 f 0208000 0210000 0218000 4000000 1a3 0 1 c 1 0 0208000 64
0 f 0208000 0210000 0218000 4000000 1e5 0 2 8 1 1 0210000 64
0 f 0208000 0210000 0218000 4000000 000 0 4 0 1 2 0218000 64
0 f 0208000 0210000 0218000 4000000 000 0 8 0 1 3 4000000 64
0 f 0208000 0210000 0218000 4000000 000 0 1 0 1 0 0208000 64
0 f 0208000 0210000 0218000 4000000 000 0 2 0 1 1 0210000 64
0 f 0208000 0210000 0218000 4000000 000 0 4 0 1 2 0218000 64
0 f 0208000 0210000 0218000 4000000 000 0 1 0 1 0 0208000 64
0 8 0208000 0210000 0218000 0220000 000 0 8 0 1 3 0220000 64
0 1 2000000 0000000 0000000 0000000 000 0 1 0 1 0 2000000 64
0 4 0000000 0000000 0218000 0000000 000 0 4 0 1 2 0218000 64
0 2 0000000 2800000 0000000 0000000 000 0 0 0 0 0 0000000 64
0 2 0000000 2800000 0000000 0000000 000 0 2 0 1 1 2800000 64
0 1 3000000 0000000 0000000 0000000 000 0 0 0 0 0 0000000 64
0 1 3000000 0000000 0000000 0000000 000 0 1 0 1 0 3000000 64
0 f 0208000 0210000 0218000 0220000 000 1 0 0 0 0 0000000 64
0 f 0208000 0210000 0218000 0220000 000 1 0 0 0 0 0000000 64
0 f 0208000 0210000 0218000 0220000 000 0 2 0 1 1 0210000 64
0 1 000008a 0000000 0000000 0000000 000 0 1 0 1 0 000008a 5
0 0 0000000 0000000 0000000 0000000 000 0 0 1 0 0 0000000 64
1 0 0000000 0000000 0000000 0000000 000 0 0 0 0 0 0000000 64
0 1 0228000 0000000 0000000 0000000 000 0 1 0 1 0 0228000 64
0 0 0000000 0000000 0000000 0000000 000 0 0 0 0 0 0000000 64

//--- vlog.f
logic/issue_pkg.sv
logic/thread_scoreboard.sv
logic/fp_pending_tracker.sv
logic/issue_arbiter.sv
logic/instruction_issue.sv
tb/issue_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the issue stage testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f vlog.f --top-module issue_tb -o issue_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "Build failed, see build.log"
	exit 1
fi

./obj_dir/issue_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^TEST PASS$" sim.log; then
	echo "Simulation passed"
	exit 0
fi
echo "Simulation failed, pass line not found in sim.log"
exit 1

//--- tb/issue_tb.sv
// Issue stage testbench

`default_nettype none

module issue_tb import issue_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int    THREAD_NUMB     = 4;
	localparam int    CLK_PERIOD      = 8;
	localparam int    RESET_CYCLES    = 8;
	localparam int    WATCHDOG_MARGIN = 20;
	localparam string STIM_FILE       = "tb/issue_stimulus.txt";

	// One row of the stimulus file, which is written for four threads
	typedef struct packed {
		logic                           apply_reset;
		logic         [THREAD_NUMB-1:0] valid;
		instruction_t [THREAD_NUMB-1:0] instrs;
		wb_result_t                     wb;
		logic                           stall;
		logic         [THREAD_NUMB-1:0] exp_mask;
		logic         [THREAD_NUMB-1:0] exp_busy;
		logic                           exp_valid;
		issue_t                         exp_issue;
	} row_t;

	logic                           clk;
	logic                           reset;
	logic         [THREAD_NUMB-1:0] instructions_valid;
	instruction_t [THREAD_NUMB-1:0] instructions;
	wb_result_t                     wb_result;
	logic                           wb_stall;
	logic                           issue_valid;
	issue_t                         issue;
	logic         [THREAD_NUMB-1:0] scheduled_mask;
	logic         [THREAD_NUMB-1:0] thread_busy;

	row_t rows[$];
	logic rows_loaded;

	instruction_issue #(
		.THREAD_NUMB(THREAD_NUMB)
	) dut (
		.clk               (clk),
		.reset             (reset),
		.instructions_valid(instructions_valid),
		.instructions      (instructions),
		.wb_result         (wb_result),
		.wb_stall          (wb_stall),
		.issue_valid       (issue_valid),
		.issue             (issue),
		.scheduled_mask    (scheduled_mask),
		.thread_busy       (thread_busy)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic end_with_failure();
		$display("TEST FAIL");
		$fatal(1, "Simulation stopped at the first failure");
	endtask

	task automatic check_mask(input string name, input string where,
		input logic [THREAD_NUMB-1:0] expected, input logic [THREAD_NUMB-1:0] actual);
		if (actual !== expected) begin
			$display("[ERROR] %s at %s: expected %h, actual %h", name, where, expected, actual);
			end_with_failure();
		end
	endtask

	task automatic check_valid(input string where, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("[ERROR] issue_valid at %s: expected %h, actual %h", where, expected, actual);
			end_with_failure();
		end
	endtask

	task automatic check_issue(input string where, input issue_t expected, input issue_t actual);
		if (actual !== expected) begin
			$display("[ERROR] issue at %s: expected %h, actual %h", where, expected, actual);
			end_with_failure();
		end
	endtask

	// Parses every data row of the stimulus file into the row queue
	task automatic load_rows();
		int                fd;
		int                count;
		int                dest_bit;
		string             line;
		row_t              row;
		logic              rst_v;
		logic        [3:0] valid_v;
		logic       [26:0] instr_v [4];
		logic        [8:0] wb_v;
		logic              stall_v;
		logic        [3:0] mask_v;
		logic        [3:0] busy_v;
		logic              next_valid_v;
		logic        [1:0] next_thread_v;
		logic       [26:0] next_instr_v;
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			$display("Could not open the stimulus file %s", STIM_FILE);
			end_with_failure();
		end
		while (!$feof(fd)) begin
			line = "";
			count = $fgets(line, fd);
			// Lines starting with a hash describe the columns
			if (count <= 0 || line[0] == "#") begin
				continue;
			end
			count = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %d",
				rst_v, valid_v, instr_v[0], instr_v[1], instr_v[2], instr_v[3], wb_v,
				stall_v, mask_v, busy_v, next_valid_v, next_thread_v, next_instr_v, dest_bit);
			if (count <= 0) begin
				continue;
			end
			if (count != 14) begin
				$display("Malformed stimulus row: %s", line);
				end_with_failure();
			end
			row.apply_reset = rst_v;
			row.valid       = valid_v;
			for (int t = 0; t < THREAD_NUMB; t++) begin
				row.instrs[t] = instr_v[t];
			end
			row.wb        = wb_v;
			row.stall     = stall_v;
			row.exp_mask  = mask_v;
			row.exp_busy  = busy_v;
			row.exp_valid = next_valid_v;
			row.exp_issue.instruction = next_instr_v;
			row.exp_issue.thread      = next_thread_v;
			// Bit 64 stands for an instruction without destination
			row.exp_issue.destination_mask = (dest_bit < 64) ? (64'd1 << dest_bit) : '0;
			rows.push_back(row);
		end
		$fclose(fd);
		if (rows.size() == 0) begin
			$display("The stimulus file holds no rows");
			end_with_failure();
		end
	endtask

	task automatic drive_row(input row_t row);
		reset              <= row.apply_reset;
		instructions_valid <= row.valid;
		instructions       <= row.instrs;
		wb_result          <= row.wb;
		wb_stall           <= row.stall;
	endtask

	// Grant and busy flags of a row are checked at the edge that ends its cycle
	// The registered issue port of a row is checked one edge later
	initial begin
		int total;
		clk                = 1'b0;
		rows_loaded        = 1'b0;
		reset              <= 1'b1;
		instructions_valid <= '0;
		instructions       <= '0;
		wb_result          <= '0;
		wb_stall           <= 1'b0;
		load_rows();
		total       = rows.size();
		rows_loaded = 1'b1;
		repeat (RESET_CYCLES - 1) @(posedge clk);
		// Reset alone must leave the port idle and every thread free
		check_valid("reset", 1'b0, issue_valid);
		check_mask("thread_busy", "reset", '0, thread_busy);
		// Reset drops at the eighth rising edge together with the first row
		for (int k = 0; k <= total + 1; k++) begin
			@(posedge clk);
			if (k >= 1 && k <= total) begin
				check_mask("scheduled_mask", $sformatf("row %0d", k - 1),
					rows[k-1].exp_mask, scheduled_mask);
				check_mask("thread_busy", $sformatf("row %0d", k - 1),
					rows[k-1].exp_busy, thread_busy);
			end
			if (k >= 2) begin
				check_valid($sformatf("row %0d", k - 2), rows[k-2].exp_valid, issue_valid);
				// The payload holds its old value while nothing is issued
				if (rows[k-2].exp_valid) begin
					check_issue($sformatf("row %0d", k - 2), rows[k-2].exp_issue, issue);
				end
			end
			if (k < total) begin
				drive_row(rows[k]);
			end
		end
		$display("TEST PASS");
		$finish;
	end

	// Limit covers reset, every row and a margin
	initial begin
		int limit;
		wait (rows_loaded);
		limit = rows.size() + RESET_CYCLES + WATCHDOG_MARGIN;
		repeat (limit) @(posedge clk);
		$display("Watchdog expired, the test did not finish within %0d clock cycles", limit);
		end_with_failure();
	end

endmodule

`default_nettype wire

//--- logic/instruction_issue.sv
// Multithreaded issue stage

`default_nettype none

module instruction_issue import issue_pkg::*; #(
	parameter int THREAD_NUMB = 4
) (
	input  logic                           clk,
	input  logic                           reset,
	input  logic         [THREAD_NUMB-1:0] instructions_valid,
	input  instruction_t [THREAD_NUMB-1:0] instructions,
	input  wb_result_t                     wb_result,
	input  logic                           wb_stall,
	output logic                           issue_valid,
	output issue_t                         issue,
	output logic         [THREAD_NUMB-1:0] scheduled_mask,
	output logic         [THREAD_NUMB-1:0] thread_busy
);

	localparam int IDX_W = $clog2(THREAD_NUMB);

	logic        [THREAD_NUMB-1:0] requests;
	logic        [THREAD_NUMB-1:0] fp_start;
	logic        [THREAD_NUMB-1:0] fp_ok;
	scoreboard_t [THREAD_NUMB-1:0] destination_masks;

	// One scoreboard per thread, each sees the shared writeback and stall
	for (genvar t = 0; t < THREAD_NUMB; t++) begin : g_thread
		thread_scoreboard #(
			.THREAD_NUMB(THREAD_NUMB)
		) u_scoreboard (
			.clk              (clk),
			.reset            (reset),
			.thread_index     (IDX_W'(t)),
			.instruction_valid(instructions_valid[t]),
			.instruction      (instructions[t]),
			.wb_result        (wb_result),
			.wb_stall         (wb_stall),
			.fp_ok            (fp_ok[t]),
			.grant            (scheduled_mask[t]),
			.request          (requests[t]),
			.fp_start         (fp_start[t]),
			.busy             (thread_busy[t]),
			.destination_mask (destination_masks[t])
		);
	end

	// The tracker sees the grant already filtered down to FP starts
	fp_pending_tracker #(
		.THREAD_NUMB(THREAD_NUMB)
	) u_fp_tracker (
		.clk         (clk),
		.reset       (reset),
		.instructions(instructions),
		.grant       (fp_start),
		.fp_ok       (fp_ok)
	);

	issue_arbiter #(
		.THREAD_NUMB(THREAD_NUMB)
	) u_arbiter (
		.clk              (clk),
		.reset            (reset),
		.requests         (requests),
		.instructions     (instructions),
		.destination_masks(destination_masks),
		.grant            (scheduled_mask),
		.issue_valid      (issue_valid),
		.issue            (issue)
	);

endmodule

`default_nettype wire

//--- logic/issue_arbiter.sv
// Round-robin issue arbiter

`default_nettype none

module issue_arbiter import issue_pkg::*; #(
	parameter int THREAD_NUMB = 4
) (
	input  logic                           clk,
	input  logic                           reset,
	input  logic         [THREAD_NUMB-1:0] requests,
	input  instruction_t [THREAD_NUMB-1:0] instructions,
	input  scoreboard_t  [THREAD_NUMB-1:0] destination_masks,
	output logic         [THREAD_NUMB-1:0] grant,
	output logic                           issue_valid,
	output issue_t                         issue
);

	localparam int IDX_W = $clog2(THREAD_NUMB);

	logic [IDX_W-1:0] last_winner;
	logic [IDX_W-1:0] winner;
	logic             any_request;

	assign any_request = |requests;

	// Search starts just after the previous winner and takes the first requester
	always_comb begin
		int  candidate;
		logic found;
		grant = '0;
		found = 1'b0;
		for (int i = 1; i <= THREAD_NUMB; i++) begin
			candidate = (int'(last_winner) + i) % THREAD_NUMB;
			if (!found && requests[candidate]) begin
				grant[candidate] = 1'b1;
				found            = 1'b1;
			end
		end
	end

	// The grant is one-hot, so OR-ing the indexes of set bits gives the winner
	always_comb begin
		winner = '0;
		for (int t = 0; t < THREAD_NUMB; t++) begin
			if (grant[t]) begin
				winner = winner | IDX_W'(t);
			end
		end
	end

	// Pointer starts at the last thread so thread 0 wins first after reset
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			last_winner <= IDX_W'(THREAD_NUMB - 1);
			issue_valid <= 1'b0;
		end else begin
			issue_valid <= any_request;
			if (any_request) begin
				last_winner <= winner;
			end
		end
	end

	// Payload only changes when something is issued
	always_ff @(posedge clk) begin
		if (any_request) begin
			issue.instruction      <= instructions[winner];
			issue.thread           <= winner;
			issue.destination_mask <= destination_masks[winner];
		end
	end

endmodule

`default_nettype wire

//--- logic/fp_pending_tracker.sv
// FP completion tracker

`default_nettype none

module fp_pending_tracker import issue_pkg::*; #(
	parameter int THREAD_NUMB = 4
) (
	input  logic                             clk,
	input  logic                             reset,
	input  instruction_t [THREAD_NUMB-1:0]   instructions,
	input  logic         [THREAD_NUMB-1:0]   grant,
	output logic         [THREAD_NUMB-1:0]   fp_ok
);

	// Bit k set means an FP result leaves the pipe k+1 cycles from now
	logic [FP_QUEUE_LEN-1:0] fp_queue;
	logic [FP_QUEUE_LEN-1:0] fp_queue_next;

	// Latency of each FP operation, add and sub share the adder
	function automatic int op_latency(input fp_op_t op);
		int latency;
		case (op)
			FP_ADD, FP_SUB: latency = FP_ADD_LAT;
			FP_MUL:         latency = FP_MUL_LAT;
			FP_DIV:         latency = FP_DIV_LAT;
			FP_ITOF:        latency = FP_ITOF_LAT;
			FP_FTOI:        latency = FP_FTOI_LAT;
			// Compares and the unused code finish after one cycle
			default:        latency = FP_CMP_LAT;
		endcase
		return latency;
	endfunction

	// An operation may start only if its finishing slot is still free
	always_comb begin
		for (int t = 0; t < THREAD_NUMB; t++) begin
			fp_ok[t] = !fp_queue[op_latency(instructions[t].fp_op) - 1];
		end
	end

	// Every slot moves one step closer to completion each cycle
	// The grant input carries only FP starts, so at most one bit is set
	always_comb begin
		fp_queue_next = fp_queue >> 1;
		for (int t = 0; t < THREAD_NUMB; t++) begin
			if (grant[t]) begin
				fp_queue_next[op_latency(instructions[t].fp_op) - 1] = 1'b1;
			end
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			fp_queue <= '0;
		end else begin
			fp_queue <= fp_queue_next;
		end
	end

endmodule

`default_nettype wire

//--- logic/thread_scoreboard.sv
// Per-thread scoreboard

`default_nettype none

module thread_scoreboard import issue_pkg::*; #(
	parameter int THREAD_NUMB = 4
) (
	input  logic                           clk,
	input  logic                           reset,
	input  logic [$clog2(THREAD_NUMB)-1:0] thread_index,
	input  logic                           instruction_valid,
	input  instruction_t                   instruction,
	input  wb_result_t                     wb_result,
	input  logic                           wb_stall,
	input  logic                           fp_ok,
	input  logic                           grant,
	output logic                           request,
	output logic                           fp_start,
	output logic                           busy,
	output scoreboard_t                    destination_mask
);

	localparam int SYNC_W = $clog2(SYNC_HOLD + 1);

	scoreboard_t scoreboard;
	scoreboard_t scoreboard_next;
	scoreboard_t source_mask;
	scoreboard_t release_mask;
	scoreboard_t set_mask;
	logic        hazard_raw;
	logic        hazard_waw;
	logic        is_fp;
	logic        is_sync;
	logic        [SYNC_W-1:0] sync_count;

	// Every register maps to one scoreboard bit indexed by {is_vector, number}
	always_comb begin
		source_mask      = '0;
		destination_mask = '0;
		release_mask     = '0;
		// A masked operation implicitly reads the scalar mask register
		if (instruction.mask_enable) begin
			source_mask[{1'b0, MASK_REG}] = 1'b1;
		end
		if (instruction.has_source0) begin
			source_mask[{instruction.is_source0_vector, instruction.source0}] = 1'b1;
		end
		if (instruction.has_source1) begin
			source_mask[{instruction.is_source1_vector, instruction.source1}] = 1'b1;
		end
		destination_mask[{instruction.is_destination_vector, instruction.destination}] =
			instruction.has_destination;
		// Only writebacks of this thread free its registers
		release_mask[{wb_result.is_vector, wb_result.register}] =
			wb_result.valid && (wb_result.thread == thread_index);
	end

	// A read of a pending register is RAW, a second pending write to it is WAW
	assign hazard_raw = |(source_mask & scoreboard);
	assign hazard_waw = |(destination_mask & scoreboard);

	assign is_fp   = instruction.pipe_sel == PIPE_FP;
	assign is_sync = instruction.pipe_sel == PIPE_SYNC;

	// The FP verdict only matters for instructions bound to the FP pipe
	assign request = instruction_valid && !hazard_raw && !hazard_waw && !wb_stall &&
		(!is_fp || fp_ok) && (sync_count == '0);

	// Tells the FP tracker that this thread starts an FP operation now
	assign fp_start = grant && is_fp;

	// The release is applied first so that a same-cycle set survives
	assign set_mask        = destination_mask & {$bits(scoreboard_t){grant}};
	assign scoreboard_next = (scoreboard & ~release_mask) | set_mask;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			scoreboard <= '0;
		end else begin
			scoreboard <= scoreboard_next;
		end
	end

	assign busy = |scoreboard;

	// Loaded on a sync grant, so the thread stays quiet for SYNC_HOLD cycles
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			sync_count <= '0;
		end else if (grant && is_sync) begin
			sync_count <= SYNC_W'(SYNC_HOLD);
		end else if (sync_count != '0) begin
			sync_count <= sync_count - 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- logic/issue_pkg.sv
// Issue stage definitions

`default_nettype none

package issue_pkg;

	// Register number inside one register file, scalar or vector
	typedef logic [4:0] reg_addr_t;

	// One busy bit per register
	// Scalar registers sit in the low half and vector registers in the high half
	typedef logic [63:0] scoreboard_t;

	// Scalar register that holds the lane mask of masked vector operations
	localparam reg_addr_t MASK_REG = 5'd31;

	// Execution pipe that an instruction is sent to
	typedef enum logic [1:0] {
		PIPE_INT,
		PIPE_FP,
		PIPE_SYNC
	} pipe_t;

	// Single precision FP operation, decoded only when the pipe is PIPE_FP
	typedef enum logic [2:0] {
		FP_ADD,
		FP_SUB,
		FP_MUL,
		FP_DIV,
		FP_CMP,
		FP_ITOF,
		FP_FTOI
	} fp_op_t;

	// Cycles from FP issue to the FP result leaving the pipe
	localparam int FP_ADD_LAT  = 4;
	localparam int FP_MUL_LAT  = 3;
	localparam int FP_DIV_LAT  = 17;
	localparam int FP_CMP_LAT  = 1;
	localparam int FP_ITOF_LAT = 3;
	localparam int FP_FTOI_LAT = 2;

	// The divider is the slowest unit, so its latency sets the queue length
	localparam int FP_QUEUE_LEN = 17;

	// Cycles a thread stays blocked after one of its sync instructions is issued
	localparam int SYNC_HOLD = 4;

	// Decoded instruction as offered by one thread
	typedef struct packed {
		pipe_t     pipe_sel;
		fp_op_t    fp_op;
		logic      has_source0;
		logic      is_source0_vector;
		reg_addr_t source0;
		logic      has_source1;
		logic      is_source1_vector;
		reg_addr_t source1;
		logic      has_destination;
		logic      is_destination_vector;
		reg_addr_t destination;
		logic      mask_enable;
	} instruction_t;

	// Register release reported by the writeback stage
	// The thread field is sized for four threads
	typedef struct packed {
		logic      valid;
		logic [1:0] thread;
		logic      is_vector;
		reg_addr_t register;
	} wb_result_t;

	// Content of the registered issue port
	typedef struct packed {
		instruction_t instruction;
		logic [1:0]   thread;
		scoreboard_t  destination_mask;
	} issue_t;

endpackage

`default_nettype wire
